// File: sources.f
+incdir+verilog
verilog/exec_pkg.sv
verilog/alu.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/branch_unit.sv
verilog/mem_access.sv
verilog/execute.sv
dv/tb_execute.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module tb_execute \
   -Mdir obj_dir -o sim_execute
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_execute > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "All tests passed!" sim.log; then
   exit 0
fi
exit 1

// File: dv/tb_execute.sv
`timescale 1ns/1ns
`include "exec_consts.svh"

module tb_execute;

   localparam int TIMEOUT = 20;

   logic                   i_clk = 1'b0;
   logic                   i_rst;
   logic [`INST_W-1:0]     i_inst;
   logic                   i_inst_valid;
   logic [`XLEN-1:0]       i_pc;
   logic                   i_wr_ready;
   logic [`XLEN-1:0]       i_data;
   logic                   i_rd_valid;
   logic [`XLEN-1:0]       o_addr;
   logic [`XLEN-1:0]       o_data;
   logic [`WR_WIDTH_W-1:0] o_wr_width;
   logic                   o_wr_valid;
   logic                   o_rd_ready;
   logic                   o_pc_change;
   logic [`XLEN-1:0]       o_new_pc;
   logic                   o_finished;
   logic                   o_invalid_inst;

   // Outputs captured on the finishing edge
   logic [`XLEN-1:0]       cap_addr;
   logic [`XLEN-1:0]       cap_data;
   logic [`WR_WIDTH_W-1:0] cap_width;
   logic                   cap_wr_valid;
   logic                   cap_rd_ready;
   logic                   cap_pc_change;
   logic [`XLEN-1:0]       cap_new_pc;
   logic                   cap_invalid;
   int                     fin_cycles;

   int seed;
   int errors = 0;
   int checks = 0;

   execute dut0 (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_inst         (i_inst),
      .i_inst_valid   (i_inst_valid),
      .i_pc           (i_pc),
      .o_addr         (o_addr),
      .o_data         (o_data),
      .o_wr_width     (o_wr_width),
      .o_wr_valid     (o_wr_valid),
      .i_wr_ready     (i_wr_ready),
      .i_data         (i_data),
      .i_rd_valid     (i_rd_valid),
      .o_rd_ready     (o_rd_ready),
      .o_pc_change    (o_pc_change),
      .o_new_pc       (o_new_pc),
      .o_finished     (o_finished),
      .o_invalid_inst (o_invalid_inst)
   );

   always #5 i_clk = ~i_clk;

   task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error: %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error: %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_width(input string name, input logic [`WR_WIDTH_W-1:0] got,
                              input logic [`WR_WIDTH_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error: %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic report_test(input string name, input int err0);
      $display("%s: %s (%0d errors)", name, (errors == err0) ? "ok" : "FAILED", errors - err0);
   endtask

   // Instruction encoders
   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, exec_pkg::OP_REG};
   endfunction

   function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], exec_pkg::STORE};
   endfunction

   function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], exec_pkg::BRANCH};
   endfunction

   function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
      return {imm, rd, op};
   endfunction

   function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, exec_pkg::JAL};
   endfunction

   function automatic logic [31:0] sext12(input logic [11:0] x);
      return {{20{x[11]}}, x};
   endfunction

   // Expected results from the RV32I rules
   function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'b000:  return alt ? a - b : a + b;
         3'b001:  return a << b[4:0];
         3'b010:  return {31'b0, $signed(a) < $signed(b)};
         3'b011:  return {31'b0, a < b};
         3'b100:  return a ^ b;
         3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'b110:  return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic [31:0] load_ref(input logic [2:0] f3, input logic [31:0] d);
      case (f3)
         3'b000:  return {{24{d[7]}}, d[7:0]};
         3'b001:  return {{16{d[15]}}, d[15:0]};
         3'b100:  return {24'b0, d[7:0]};
         3'b101:  return {16'b0, d[15:0]};
         default: return d;
      endcase
   endfunction

   function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
      case (f3)
         3'b000:  return a == b;
         3'b001:  return a != b;
         3'b100:  return $signed(a) < $signed(b);
         3'b101:  return $signed(a) >= $signed(b);
         3'b110:  return a < b;
         3'b111:  return a >= b;
         default: return 1'b0;
      endcase
   endfunction

   // Holds one instruction until o_finished while memory answers after delay cycles
   task automatic exec_inst(input logic [31:0] inst, input logic [31:0] pc,
                            input int delay, input logic [31:0] rdata);
      int               cycles;
      logic             done;
      logic [`XLEN-1:0] first_addr;
      logic [`XLEN-1:0] first_data;
      cycles = 0;
      done = 1'b0;
      fin_cycles = -1;
      @(negedge i_clk);
      i_inst = inst;
      i_pc = pc;
      i_data = rdata;
      i_inst_valid = 1'b1;
      while (!done) begin
         i_wr_ready = (cycles >= delay);
         i_rd_valid = (cycles >= delay);
         @(posedge i_clk);
         if (cycles == 0) begin
            first_addr = o_addr;
            first_data = o_data;
         end else begin
            check_word("o_addr", o_addr, first_addr);
            check_word("o_data", o_data, first_data);
         end
         if (o_finished) begin
            done = 1'b1;
            fin_cycles = cycles;
            cap_addr = o_addr;
            cap_data = o_data;
            cap_width = o_wr_width;
            cap_wr_valid = o_wr_valid;
            cap_rd_ready = o_rd_ready;
            cap_pc_change = o_pc_change;
            cap_new_pc = o_new_pc;
            cap_invalid = o_invalid_inst;
         end else if (cycles >= TIMEOUT) begin
            errors++;
            $display("Timeout: instruction %h did not finish in %0d cycles", inst, TIMEOUT);
            done = 1'b1;
         end else begin
            check_bit("o_wr_valid | o_rd_ready", o_wr_valid | o_rd_ready, 1'b1);
            cycles++;
            @(negedge i_clk);
         end
      end
      @(negedge i_clk);
      i_inst_valid = 1'b0;
      i_wr_ready = 1'b0;
      i_rd_valid = 1'b0;
   endtask

   task automatic set_reg(input logic [4:0] rd, input logic [31:0] v);
      logic [31:0] upper;
      upper = v + 32'h800;
      exec_inst(u_type(upper[31:12], rd, exec_pkg::LUI), 32'h0, 0, 32'h0);
      exec_inst(i_type(v[11:0], rd, 3'b000, rd, exec_pkg::OP_IMM), 32'h0, 0, 32'h0);
   endtask

   // SW rs, 0(x0) exposes the register on o_data
   task automatic read_reg(input logic [4:0] rs, output logic [31:0] v);
      exec_inst(s_type(12'h0, rs, 5'd0, 3'b010), 32'h0, 0, 32'h0);
      v = cap_data;
   endtask

   task automatic reset_state;
      int          err0;
      logic [31:0] got;
      err0 = errors;
      @(posedge i_clk);
      check_bit("o_wr_valid", o_wr_valid, 1'b0);
      check_bit("o_rd_ready", o_rd_ready, 1'b0);
      check_bit("o_pc_change", o_pc_change, 1'b0);
      check_bit("o_finished", o_finished, 1'b0);
      check_bit("o_invalid_inst", o_invalid_inst, 1'b0);
      for (int r = 1; r < 32; r += 15) begin
         read_reg(5'(r), got);
         check_word("reset register", got, 32'h0);
      end
      report_test("reset_state", err0);
   endtask

   task automatic alu_ops;
      int          err0;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] got;
      logic [11:0] imm12;
      logic [2:0]  f3;
      logic        alt;
      err0 = errors;
      for (int n = 0; n < 3; n++) begin
         a = $random(seed);
         b = $random(seed);
         set_reg(5'd1, a);
         set_reg(5'd2, b);
         // Entries 8 and 9 are SUB and SRA
         for (int f = 0; f < 10; f++) begin
            f3 = (f < 8) ? 3'(f) : ((f == 8) ? 3'b000 : 3'b101);
            alt = (f >= 8);
            exec_inst(r_type(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3), 32'h0, 0, 32'h0);
            read_reg(5'd3, got);
            check_word("reg result", got, alu_ref(f3, alt, a, b));
            if (f != 8) begin
               imm12 = 12'($random(seed));
               if (f3 == 3'b001 || f3 == 3'b101)
                  imm12 = {alt ? 7'h20 : 7'h00, imm12[4:0]};
               exec_inst(i_type(imm12, 5'd1, f3, 5'd3, exec_pkg::OP_IMM), 32'h0, 0, 32'h0);
               read_reg(5'd3, got);
               check_word("imm result", got, alu_ref(f3, alt, a, sext12(imm12)));
            end
         end
      end
      report_test("alu_ops", err0);
   endtask

   task automatic upper_imm;
      int          err0;
      logic [19:0] imm20;
      logic [31:0] pc;
      logic [31:0] got;
      err0 = errors;
      imm20 = 20'($random(seed));
      pc = $random(seed) & 32'hFFFF_FFFC;
      exec_inst(u_type(imm20, 5'd4, exec_pkg::LUI), 32'h0, 0, 32'h0);
      read_reg(5'd4, got);
      check_word("lui value", got, {imm20, 12'b0});
      exec_inst(u_type(imm20, 5'd4, exec_pkg::AUIPC), pc, 0, 32'h0);
      read_reg(5'd4, got);
      check_word("auipc value", got, pc + {imm20, 12'b0});
      report_test("upper_imm", err0);
   endtask

   task automatic loads;
      int          err0;
      int          delay;
      logic [31:0] base;
      logic [31:0] data;
      logic [31:0] got;
      logic [11:0] off;
      err0 = errors;
      base = $random(seed);
      set_reg(5'd6, base);
      for (int f = 0; f < 6; f++) begin
         if (f == 3)
            continue;
         off = 12'($random(seed));
         data = $random(seed);
         delay = {$random(seed)} % 6;
         exec_inst(i_type(off, 5'd6, 3'(f), 5'd7, exec_pkg::LOAD), 32'h100, delay, data);
         check_word("load o_addr", cap_addr, base + sext12(off));
         check_word("load finish cycle", 32'(fin_cycles), 32'(delay));
         check_bit("o_rd_ready", cap_rd_ready, 1'b1);
         check_bit("o_wr_valid", cap_wr_valid, 1'b0);
         read_reg(5'd7, got);
         check_word("load value", got, load_ref(3'(f), data));
      end
      report_test("loads", err0);
   endtask

   task automatic stores;
      int          err0;
      int          delay;
      logic [31:0] base;
      logic [31:0] val;
      logic [11:0] off;
      err0 = errors;
      base = $random(seed);
      val = $random(seed);
      set_reg(5'd8, base);
      set_reg(5'd9, val);
      for (int f = 0; f < 3; f++) begin
         off = 12'($random(seed));
         delay = {$random(seed)} % 6;
         exec_inst(s_type(off, 5'd9, 5'd8, 3'(f)), 32'h200, delay, 32'h0);
         check_width("o_wr_width", cap_width, 3'(1 << f));
         check_word("store o_addr", cap_addr, base + sext12(off));
         check_word("store o_data", cap_data, val);
         check_bit("o_wr_valid", cap_wr_valid, 1'b1);
         check_word("store finish cycle", 32'(fin_cycles), 32'(delay));
      end
      report_test("stores", err0);
   endtask

   task automatic jumps_branches;
      int          err0;
      logic [31:0] pc;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] got;
      logic [20:0] imm21;
      logic [12:0] imm13;
      logic [11:0] imm12;
      logic        taken;
      err0 = errors;
      pc = $random(seed) & 32'hFFFF_FFFC;
      imm21 = 21'($random(seed)) & 21'h1F_FFFE;
      exec_inst(j_type(imm21, 5'd10), pc, 0, 32'h0);
      check_bit("jal o_pc_change", cap_pc_change, 1'b1);
      check_word("jal o_new_pc", cap_new_pc, pc + {{11{imm21[20]}}, imm21});
      read_reg(5'd10, got);
      check_word("jal link", got, pc + 32'd4);
      a = $random(seed) | 32'h1;
      imm12 = 12'($random(seed));
      set_reg(5'd11, a);
      exec_inst(i_type(imm12, 5'd11, 3'b000, 5'd12, exec_pkg::JALR), pc, 0, 32'h0);
      check_bit("jalr o_pc_change", cap_pc_change, 1'b1);
      check_word("jalr o_new_pc", cap_new_pc, (a + sext12(imm12)) & 32'hFFFF_FFFE);
      read_reg(5'd12, got);
      check_word("jalr link", got, pc + 32'd4);
      // Equal, random, and operands that differ only in signedness
      for (int p = 0; p < 4; p++) begin
         a = $random(seed);
         case (p)
            0: b = a;
            1: b = $random(seed);
            2: begin
               a = 32'hFFFF_FFF0;
               b = 32'd5;
            end
            default: begin
               a = 32'd5;
               b = 32'hFFFF_FFF0;
            end
         endcase
         set_reg(5'd13, a);
         set_reg(5'd14, b);
         for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3)
               continue;
            imm13 = 13'($random(seed)) & 13'h1FFE;
            exec_inst(b_type(imm13, 5'd14, 5'd13, 3'(f)), pc, 0, 32'h0);
            taken = branch_ref(3'(f), a, b);
            check_bit("branch o_pc_change", cap_pc_change, taken);
            if (taken)
               check_word("branch o_new_pc", cap_new_pc, pc + {{19{imm13[12]}}, imm13});
         end
      end
      exec_inst(i_type(12'h005, 5'd0, 3'b000, 5'd0, exec_pkg::OP_IMM), 32'h0, 0, 32'h0);
      exec_inst(j_type(21'h10, 5'd0), pc, 0, 32'h0);
      read_reg(5'd0, got);
      check_word("x0 value", got, 32'h0);
      report_test("jumps_branches", err0);
   endtask

   task automatic invalid_inst;
      int err0;
      err0 = errors;
      exec_inst(32'h0000_007F, 32'h0, 0, 32'h0);
      check_bit("o_invalid_inst unknown opcode", cap_invalid, 1'b1);
      exec_inst(r_type(7'h21, 5'd2, 5'd1, 3'b101, 5'd3), 32'h0, 0, 32'h0);
      check_bit("o_invalid_inst sra funct7", cap_invalid, 1'b1);
      exec_inst(r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd3), 32'h0, 0, 32'h0);
      check_bit("o_invalid_inst sub funct7", cap_invalid, 1'b1);
      exec_inst(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), 32'h0, 0, 32'h0);
      check_bit("o_invalid_inst legal sub", cap_invalid, 1'b0);
      report_test("invalid_inst", err0);
   endtask

   initial begin
      seed = 32'h2339_a65a;
      i_rst = 1'b1;
      i_inst = '0;
      i_inst_valid = 1'b0;
      i_pc = '0;
      i_wr_ready = 1'b0;
      i_data = '0;
      i_rd_valid = 1'b0;
      repeat (8) @(posedge i_clk);
      @(negedge i_clk);
      i_rst = 1'b0;

      reset_state();
      alu_ops();
      upper_imm();
      loads();
      stores();
      jumps_branches();
      invalid_inst();

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

// File: verilog/execute.sv
`timescale 1ns/1ns
`include "exec_consts.svh"

module execute (
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  logic [`INST_W-1:0]     i_inst,
   input  logic                   i_inst_valid,
   input  logic [`XLEN-1:0]       i_pc,
   output logic [`XLEN-1:0]       o_addr,
   output logic [`XLEN-1:0]       o_data,
   output logic [`WR_WIDTH_W-1:0] o_wr_width,
   output logic                   o_wr_valid,
   input  logic                   i_wr_ready,
   input  logic [`XLEN-1:0]       i_data,
   input  logic                   i_rd_valid,
   output logic                   o_rd_ready,
   output logic                   o_pc_change,
   output logic [`XLEN-1:0]       o_new_pc,
   output logic                   o_finished,
   output logic                   o_invalid_inst
);
   exec_pkg::opcode_e      opcode;
   exec_pkg::alu_op_e      alu_op;
   logic [2:0]             funct3;
   logic [`REG_ADDR_W-1:0] rd;
   logic [`REG_ADDR_W-1:0] rs1;
   logic [`REG_ADDR_W-1:0] rs2;
   logic [`XLEN-1:0]       rs1_data;
   logic [`XLEN-1:0]       rs2_data;
   logic [`XLEN-1:0]       alu_a;
   logic [`XLEN-1:0]       alu_b;
   logic [`XLEN-1:0]       alu_result;
   logic [`XLEN-1:0]       u_imm;
   logic [`XLEN-1:0]       load_value;
   logic [`XLEN-1:0]       wb_data;
   logic                   writes_rd;
   logic                   dec_invalid;
   logic                   reg_we;

   inst_decoder u_decoder (
      .i_inst      (i_inst),
      .i_pc        (i_pc),
      .i_rs1_data  (rs1_data),
      .i_rs2_data  (rs2_data),
      .o_opcode    (opcode),
      .o_funct3    (funct3),
      .o_rd        (rd),
      .o_rs1       (rs1),
      .o_rs2       (rs2),
      .o_alu_op    (alu_op),
      .o_alu_a     (alu_a),
      .o_alu_b     (alu_b),
      .o_u_imm     (u_imm),
      .o_writes_rd (writes_rd),
      .o_invalid   (dec_invalid)
   );

   alu u_alu (
      .i_op     (alu_op),
      .i_a      (alu_a),
      .i_b      (alu_b),
      .o_result (alu_result)
   );

   reg_file u_reg_file (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_we     (reg_we),
      .i_waddr  (rd),
      .i_wdata  (wb_data),
      .i_raddr1 (rs1),
      .i_raddr2 (rs2),
      .o_rdata1 (rs1_data),
      .o_rdata2 (rs2_data)
   );

   branch_unit u_branch (
      .i_valid     (i_inst_valid),
      .i_opcode    (opcode),
      .i_funct3    (funct3),
      .i_rs1_data  (rs1_data),
      .i_rs2_data  (rs2_data),
      .i_target    (alu_result),
      .o_pc_change (o_pc_change),
      .o_new_pc    (o_new_pc)
   );

   mem_access u_mem (
      .i_valid      (i_inst_valid),
      .i_opcode     (opcode),
      .i_funct3     (funct3),
      .i_addr       (alu_result),
      .i_store_data (rs2_data),
      .i_wr_ready   (i_wr_ready),
      .i_rd_valid   (i_rd_valid),
      .i_data       (i_data),
      .o_addr       (o_addr),
      .o_data       (o_data),
      .o_wr_width   (o_wr_width),
      .o_wr_valid   (o_wr_valid),
      .o_rd_ready   (o_rd_ready),
      .o_load_value (load_value),
      .o_finished   (o_finished)
   );

   // Write-back source
   always_comb begin
      case (opcode)
         exec_pkg::LUI:                 wb_data = u_imm;
         exec_pkg::JAL, exec_pkg::JALR: wb_data = i_pc + `XLEN'(`PC_STEP);
         exec_pkg::LOAD:                wb_data = load_value;
         default:                       wb_data = alu_result;
      endcase
   end

   // Loads write on the handshake edge, everything else on the valid cycle
   assign reg_we         = i_inst_valid && writes_rd && o_finished && !dec_invalid;
   assign o_invalid_inst = i_inst_valid && dec_invalid;

endmodule

// File: verilog/mem_access.sv
`timescale 1ns/1ns
`include "exec_consts.svh"

module mem_access (
   input  logic                   i_valid,
   input  exec_pkg::opcode_e      i_opcode,
   input  logic [2:0]             i_funct3,
   input  logic [`XLEN-1:0]       i_addr,
   input  logic [`XLEN-1:0]       i_store_data,
   input  logic                   i_wr_ready,
   input  logic                   i_rd_valid,
   input  logic [`XLEN-1:0]       i_data,
   output logic [`XLEN-1:0]       o_addr,
   output logic [`XLEN-1:0]       o_data,
   output logic [`WR_WIDTH_W-1:0] o_wr_width,
   output logic                   o_wr_valid,
   output logic                   o_rd_ready,
   output logic [`XLEN-1:0]       o_load_value,
   output logic                   o_finished
);
   exec_pkg::load_fn_e load_fn;
   logic               is_load;
   logic               is_store;

   assign load_fn  = exec_pkg::load_fn_e'(i_funct3);
   assign is_load  = i_valid && (i_opcode == exec_pkg::LOAD);
   assign is_store = i_valid && (i_opcode == exec_pkg::STORE);

   assign o_wr_valid = is_store;
   assign o_rd_ready = is_load;
   assign o_addr     = (is_load || is_store) ? i_addr : '0;
   assign o_data     = is_store ? i_store_data : '0;

   // SB, SH, SW
   always_comb begin
      o_wr_width = '0;
      if (is_store) begin
         case (i_funct3)
            3'b000:  o_wr_width = `WR_WIDTH_W'(1);
            3'b001:  o_wr_width = `WR_WIDTH_W'(2);
            3'b010:  o_wr_width = `WR_WIDTH_W'(4);
            default: o_wr_width = '0;
         endcase
      end
   end

   always_comb begin
      case (load_fn)
         exec_pkg::LB:  o_load_value = {{(`XLEN-8){i_data[7]}}, i_data[7:0]};
         exec_pkg::LH:  o_load_value = {{(`XLEN-16){i_data[15]}}, i_data[15:0]};
         exec_pkg::LBU: o_load_value = {{(`XLEN-8){1'b0}}, i_data[7:0]};
         exec_pkg::LHU: o_load_value = {{(`XLEN-16){1'b0}}, i_data[15:0]};
         default:       o_load_value = i_data;
      endcase
   end

   // Memory instructions end on the handshake, all others in one cycle
   always_comb begin
      if (is_store)
         o_finished = i_wr_ready;
      else if (is_load)
         o_finished = i_rd_valid;
      else
         o_finished = i_valid;
   end

   always_comb begin
      assert (!(o_wr_valid && o_rd_ready))
         else $error("mem_access: read and write strobes raised together");
   end

endmodule

// File: verilog/branch_unit.sv
`timescale 1ns/1ns
`include "exec_consts.svh"

module branch_unit (
   input  logic              i_valid,
   input  exec_pkg::opcode_e i_opcode,
   input  logic [2:0]        i_funct3,
   input  logic [`XLEN-1:0]  i_rs1_data,
   input  logic [`XLEN-1:0]  i_rs2_data,
   input  logic [`XLEN-1:0]  i_target,
   output logic              o_pc_change,
   output logic [`XLEN-1:0]  o_new_pc
);
   exec_pkg::branch_fn_e fn;
   logic                 taken;

   assign fn = exec_pkg::branch_fn_e'(i_funct3);

   always_comb begin
      case (fn)
         exec_pkg::BEQ:  taken = (i_rs1_data == i_rs2_data);
         exec_pkg::BNE:  taken = (i_rs1_data != i_rs2_data);
         exec_pkg::BLT:  taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
         exec_pkg::BGE:  taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
         exec_pkg::BLTU: taken = (i_rs1_data < i_rs2_data);
         exec_pkg::BGEU: taken = (i_rs1_data >= i_rs2_data);
         default:        taken = 1'b0;
      endcase
   end

   always_comb begin
      o_pc_change = 1'b0;
      o_new_pc    = '0;
      if (i_valid) begin
         case (i_opcode)
            exec_pkg::JAL: begin
               o_pc_change = 1'b1;
               o_new_pc    = i_target;
            end
            exec_pkg::JALR: begin
               o_pc_change = 1'b1;
               o_new_pc    = {i_target[`XLEN-1:1], 1'b0};
            end
            exec_pkg::BRANCH: begin
               o_pc_change = taken;
               o_new_pc    = taken ? i_target : '0;
            end
            default: ;
         endcase
      end
   end

   // Targets come from the decoder immediates, which are always even
   always_comb begin
      if (o_pc_change) begin
         assert (o_new_pc[0] == 1'b0)
            else $error("branch_unit: odd target %h requested", o_new_pc);
      end
   end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ns
`include "exec_consts.svh"

module reg_file (
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  logic                   i_we,
   input  logic [`REG_ADDR_W-1:0] i_waddr,
   input  logic [`XLEN-1:0]       i_wdata,
   input  logic [`REG_ADDR_W-1:0] i_raddr1,
   input  logic [`REG_ADDR_W-1:0] i_raddr2,
   output logic [`XLEN-1:0]       o_rdata1,
   output logic [`XLEN-1:0]       o_rdata2
);
   logic [`XLEN-1:0] regs [`NUM_REGS];

   // x0 is never written, so it stays at its reset value of zero
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we && i_waddr != '0) begin
         regs[i_waddr] <= i_wdata;
      end
   end

   assign o_rdata1 = regs[i_raddr1];
   assign o_rdata2 = regs[i_raddr2];

   assert property (@(posedge i_clk) disable iff (i_rst)
      (i_we && i_waddr == '0) |=> (regs[0] == '0))
      else $error("reg_file: x0 changed after a write to index 0");

endmodule

// File: verilog/inst_decoder.sv
`timescale 1ns/1ns
`include "exec_consts.svh"

module inst_decoder (
   input  logic [`INST_W-1:0]     i_inst,
   input  logic [`XLEN-1:0]       i_pc,
   input  logic [`XLEN-1:0]       i_rs1_data,
   input  logic [`XLEN-1:0]       i_rs2_data,
   output exec_pkg::opcode_e      o_opcode,
   output logic [2:0]             o_funct3,
   output logic [`REG_ADDR_W-1:0] o_rd,
   output logic [`REG_ADDR_W-1:0] o_rs1,
   output logic [`REG_ADDR_W-1:0] o_rs2,
   output exec_pkg::alu_op_e      o_alu_op,
   output logic [`XLEN-1:0]       o_alu_a,
   output logic [`XLEN-1:0]       o_alu_b,
   output logic [`XLEN-1:0]       o_u_imm,
   output logic                   o_writes_rd,
   output logic                   o_invalid
);
   logic [6:0]       funct7;
   logic             is_reg;
   logic [`XLEN-1:0] imm_i;
   logic [`XLEN-1:0] imm_s;
   logic [`XLEN-1:0] imm_b;
   logic [`XLEN-1:0] imm_j;

   assign o_opcode = exec_pkg::opcode_e'(i_inst[6:0]);
   assign o_rd     = i_inst[11:7];
   assign o_funct3 = i_inst[14:12];
   assign o_rs1    = i_inst[19:15];
   assign o_rs2    = i_inst[24:20];
   assign funct7   = i_inst[31:25];
   assign is_reg   = (o_opcode == exec_pkg::OP_REG);

   // Sign-extended immediates
   assign imm_i   = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]};
   assign imm_s   = {{(`XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
   assign imm_b   = {{(`XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                     i_inst[11:8], 1'b0};
   assign imm_j   = {{(`XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                     i_inst[30:21], 1'b0};
   assign o_u_imm = {i_inst[31:12], 12'b0};

   always_comb begin
      o_alu_op    = exec_pkg::ALU_ADD;
      o_alu_a     = i_rs1_data;
      o_alu_b     = imm_i;
      o_writes_rd = 1'b0;
      o_invalid   = 1'b0;
      case (o_opcode)
         exec_pkg::LOAD:  o_writes_rd = 1'b1;
         exec_pkg::STORE: o_alu_b = imm_s;
         exec_pkg::BRANCH: begin
            o_alu_a = i_pc;
            o_alu_b = imm_b;
         end
         exec_pkg::JAL: begin
            o_alu_a     = i_pc;
            o_alu_b     = imm_j;
            o_writes_rd = 1'b1;
         end
         exec_pkg::JALR:  o_writes_rd = 1'b1;
         exec_pkg::AUIPC: begin
            o_alu_a     = i_pc;
            o_alu_b     = o_u_imm;
            o_writes_rd = 1'b1;
         end
         exec_pkg::LUI:   o_writes_rd = 1'b1;
         exec_pkg::NOP:   ;
         exec_pkg::OP_IMM, exec_pkg::OP_REG: begin
            o_writes_rd = 1'b1;
            if (is_reg)
               o_alu_b = i_rs2_data;
            case (o_funct3)
               3'b000: begin
                  // SUB only exists in register form
                  if (is_reg && funct7 == 7'b0100000)
                     o_alu_op = exec_pkg::ALU_SUB;
                  else if (is_reg && funct7 != 7'b0000000)
                     o_invalid = 1'b1;
               end
               3'b001: begin
                  o_alu_op  = exec_pkg::ALU_SLL;
                  o_invalid = (funct7 != 7'b0000000);
               end
               3'b010: o_alu_op = exec_pkg::ALU_SLT;
               3'b011: o_alu_op = exec_pkg::ALU_SLTU;
               3'b100: o_alu_op = exec_pkg::ALU_XOR;
               3'b101: begin
                  if (funct7 == 7'b0100000)
                     o_alu_op = exec_pkg::ALU_SRA;
                  else
                     o_alu_op = exec_pkg::ALU_SRL;
                  o_invalid = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
               end
               3'b110: o_alu_op = exec_pkg::ALU_OR;
               default: o_alu_op = exec_pkg::ALU_AND;
            endcase
         end
         default: o_invalid = 1'b1;
      endcase
   end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ns
`include "exec_consts.svh"

module alu (
   input  exec_pkg::alu_op_e i_op,
   input  logic [`XLEN-1:0]  i_a,
   input  logic [`XLEN-1:0]  i_b,
   output logic [`XLEN-1:0]  o_result
);
   logic [4:0] shamt;

   assign shamt = i_b[4:0];

   always_comb begin
      case (i_op)
         exec_pkg::ALU_ADD:  o_result = i_a + i_b;
         exec_pkg::ALU_SUB:  o_result = i_a - i_b;
         exec_pkg::ALU_SLT:  o_result = {{(`XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
         exec_pkg::ALU_SLTU: o_result = {{(`XLEN-1){1'b0}}, i_a < i_b};
         exec_pkg::ALU_AND:  o_result = i_a & i_b;
         exec_pkg::ALU_OR:   o_result = i_a | i_b;
         exec_pkg::ALU_XOR:  o_result = i_a ^ i_b;
         exec_pkg::ALU_SLL:  o_result = i_a << shamt;
         exec_pkg::ALU_SRL:  o_result = i_a >> shamt;
         exec_pkg::ALU_SRA:  o_result = $signed(i_a) >>> shamt;
         default:            o_result = '0;
      endcase
   end

   // Known operands must never produce X bits
   always_comb begin
      if (!$isunknown({i_op, i_a, i_b})) begin
         assert (!$isunknown(o_result))
            else $error("alu: unknown result bits for op %0d", i_op);
      end
   end

endmodule

// File: verilog/exec_pkg.sv
package exec_pkg;

   // RV32I major opcodes
   typedef enum logic [6:0] {
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011,
      OP_IMM = 7'b0010011,
      OP_REG = 7'b0110011,
      LUI    = 7'b0110111,
      AUIPC  = 7'b0010111,
      JAL    = 7'b1101111,
      JALR   = 7'b1100111,
      BRANCH = 7'b1100011,
      // FENCE encoding, executed as a no-op
      NOP    = 7'b0001111
   } opcode_e;

   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_SLT  = 4'd2,
      ALU_SLTU = 4'd3,
      ALU_AND  = 4'd4,
      ALU_OR   = 4'd5,
      ALU_XOR  = 4'd6,
      ALU_SLL  = 4'd7,
      ALU_SRL  = 4'd8,
      ALU_SRA  = 4'd9
   } alu_op_e;

   // Branch funct3
   typedef enum logic [2:0] {
      BEQ  = 3'b000,
      BNE  = 3'b001,
      BLT  = 3'b100,
      BGE  = 3'b101,
      BLTU = 3'b110,
      BGEU = 3'b111
   } branch_fn_e;

   // Load funct3
   typedef enum logic [2:0] {
      LB  = 3'b000,
      LH  = 3'b001,
      LW  = 3'b010,
      LBU = 3'b100,
      LHU = 3'b101
   } load_fn_e;

endpackage

// File: verilog/exec_consts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Data path and address width
`define XLEN 32

// Instruction word
`define INST_W 32

// Scalar register file
`define REG_ADDR_W 5
`define NUM_REGS 32

// Return address offset for JAL and JALR
`define PC_STEP 4

// Store width code, in bytes
`define WR_WIDTH_W 3

`endif
